/* hw/lc3b_types.sv */
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// LC-3b encodings, anything unlisted decodes as op_nop
	typedef enum logic [3:0] {
		op_nop = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add, // Also used for LDR/STR address
		alu_and,
		alu_not,
		alu_pass
	} alu_op_t;

	typedef struct packed {
		logic valid;
		lc3b_opcode opcode;
		alu_op_t alu_op;
		logic use_imm; // Operand B is imm
		lc3b_word imm; // Sign-extended imm5 or offset6 << 1
		logic mem_read;
		logic mem_write;
		logic load_regfile;
		lc3b_reg dest;
	} lc3b_control;

	typedef struct packed {
		logic valid;
		lc3b_word pc;
		lc3b_word ir;
	} if_id_t;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_word pc;
		lc3b_word sr1_value;
		lc3b_word sr2_value; // Store data for STR
	} id_ex_t;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_word pc;
		lc3b_word alu;
		lc3b_word store_data;
	} ex_mem_t;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_word alu;
		lc3b_word mdr;
	} mem_wb_t;

	// In-flight register writer, seen by the interlock
	typedef struct packed {
		logic valid;
		lc3b_reg reg_num;
	} rf_dest_t;

	typedef struct packed {
		logic en;
		lc3b_reg reg_num;
		lc3b_word value;
	} reg_write_t;

	typedef struct packed {
		lc3b_word addr;
		lc3b_word wdata;
		logic write;
	} dmem_req_t;

endpackage : lc3b_types

`default_nettype wire

/* hw/instruction_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_fetch
(
	input logic clk,
	input logic reset,
	input logic hold, // mem_busy or hazard_stall
	input lc3b_types::lc3b_word mem_rdata1,
	output lc3b_types::lc3b_word mem_addr1,
	output lc3b_types::if_id_t if_id,
	output logic mem_read1
);

	import lc3b_types::*;

	lc3b_word pc;

	assign mem_addr1 = pc;
	assign mem_read1 = ~hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= 16'h0000;
		end else if (!hold) begin
			pc <= pc + 16'd2; // Word aligned, no branches
		end
	end

	// IF/ID register, frozen together with the PC
	always_ff @(posedge clk) begin
		if (reset) begin
			if_id <= '0;
		end else if (!hold) begin
			if_id.valid <= 1'b1;
			if_id.pc <= pc;
			if_id.ir <= mem_rdata1;
		end
	end

endmodule : instruction_fetch

`default_nettype wire

/* hw/instruction_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instruction_decode
(
	input logic clk,
	input logic reset,
	input lc3b_types::if_id_t if_id,
	input lc3b_types::lc3b_word sr1_value,
	input lc3b_types::lc3b_word sr2_value,
	input lc3b_types::rf_dest_t ex_dest,
	input lc3b_types::rf_dest_t mem_dest,
	input logic mem_busy,
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output logic hazard_stall,
	output lc3b_types::id_ex_t id_ex
);

	import lc3b_types::*;

	lc3b_word ir;
	lc3b_opcode opcode;
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_control ctrl;
	logic uses_sr1;
	logic uses_sr2;
	logic sr1_busy;
	logic sr2_busy;

	assign ir = if_id.ir;
	assign opcode = lc3b_opcode'(ir[15:12]);
	assign imm5 = {{11{ir[4]}}, ir[4:0]};
	assign offset6 = {{9{ir[5]}}, ir[5:0], 1'b0}; // Word offset in bytes

	// STR reads its source register through the sr2 port
	assign sr1 = ir[8:6];
	assign sr2 = (opcode == op_str) ? ir[11:9] : ir[2:0];

	always_comb begin
		ctrl = '0;
		ctrl.valid = if_id.valid;
		ctrl.opcode = op_nop;
		ctrl.alu_op = alu_pass;
		ctrl.dest = ir[11:9];
		uses_sr1 = 1'b0;
		uses_sr2 = 1'b0;
		case (opcode)
			op_add, op_and: begin
				ctrl.opcode = opcode;
				ctrl.alu_op = (opcode == op_add) ? alu_add : alu_and;
				ctrl.use_imm = ir[5];
				ctrl.imm = imm5;
				ctrl.load_regfile = 1'b1;
				uses_sr1 = 1'b1;
				uses_sr2 = ~ir[5]; // Register form only
			end
			op_not: begin
				ctrl.opcode = op_not;
				ctrl.alu_op = alu_not;
				ctrl.load_regfile = 1'b1;
				uses_sr1 = 1'b1;
			end
			op_ldr: begin
				ctrl.opcode = op_ldr;
				ctrl.alu_op = alu_add;
				ctrl.use_imm = 1'b1;
				ctrl.imm = offset6;
				ctrl.mem_read = 1'b1;
				ctrl.load_regfile = 1'b1;
				uses_sr1 = 1'b1;
			end
			op_str: begin
				ctrl.opcode = op_str;
				ctrl.alu_op = alu_add;
				ctrl.use_imm = 1'b1;
				ctrl.imm = offset6;
				ctrl.mem_write = 1'b1;
				uses_sr1 = 1'b1;
				uses_sr2 = 1'b1;
			end
			default: ; // NOP and unsupported opcodes
		endcase
	end

	// WB is covered by the register file bypass
	assign sr1_busy = (ex_dest.valid && ex_dest.reg_num == sr1) ||
		(mem_dest.valid && mem_dest.reg_num == sr1);
	assign sr2_busy = (ex_dest.valid && ex_dest.reg_num == sr2) ||
		(mem_dest.valid && mem_dest.reg_num == sr2);
	assign hazard_stall = if_id.valid && ((uses_sr1 && sr1_busy) || (uses_sr2 && sr2_busy));

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex <= '0;
		end else if (!mem_busy) begin
			if (hazard_stall) begin
				id_ex.ctrl <= '0; // Bubble
			end else begin
				id_ex.ctrl <= ctrl;
			end
			id_ex.pc <= if_id.pc;
			id_ex.sr1_value <= sr1_value;
			id_ex.sr2_value <= sr2_value;
		end
	end

endmodule : instruction_decode

`default_nettype wire

/* hw/execution_module.sv */
`timescale 1ns/1ns
`default_nettype none

module execution_module
(
	input logic clk,
	input logic reset,
	input logic mem_busy,
	input lc3b_types::id_ex_t id_ex,
	output lc3b_types::rf_dest_t ex_dest,
	output lc3b_types::ex_mem_t ex_mem
);

	import lc3b_types::*;

	lc3b_word operand_a;
	lc3b_word operand_b;
	lc3b_word alu_out;

	assign operand_a = id_ex.sr1_value;
	assign operand_b = id_ex.ctrl.use_imm ? id_ex.ctrl.imm : id_ex.sr2_value;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add: alu_out = operand_a + operand_b; // Base + offset for LDR/STR
			alu_and: alu_out = operand_a & operand_b;
			alu_not: alu_out = ~operand_a;
			default: alu_out = operand_b;
		endcase
	end

	// Pending writer in EX
	assign ex_dest.valid = id_ex.ctrl.valid && id_ex.ctrl.load_regfile;
	assign ex_dest.reg_num = id_ex.ctrl.dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem <= '0;
		end else if (!mem_busy) begin
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.pc <= id_ex.pc;
			ex_mem.alu <= alu_out;
			ex_mem.store_data <= id_ex.sr2_value;
		end
	end

endmodule : execution_module

`default_nettype wire

/* hw/memory_module.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_module
(
	input logic clk,
	input logic reset,
	input lc3b_types::ex_mem_t ex_mem,
	input logic dmem_ack,
	input lc3b_types::lc3b_word dmem_rdata,
	output logic dmem_req_valid,
	output lc3b_types::dmem_req_t dmem_req,
	output logic mem_busy,
	output lc3b_types::rf_dest_t mem_dest,
	output lc3b_types::mem_wb_t mem_wb
);

	import lc3b_types::*;

	typedef enum logic [1:0] {
		idle,
		wait_ack,
		wait_release,
		done
	} mem_state_t;

	mem_state_t state;
	logic is_mem;
	lc3b_word mdr;

	assign is_mem = ex_mem.ctrl.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

	// Front of the pipe is frozen until the handshake has closed
	assign mem_busy = is_mem && (state != done);

	// EX/MEM is held during the transfer, so these stay stable under req
	assign dmem_req.addr = ex_mem.alu;
	assign dmem_req.wdata = ex_mem.store_data;
	assign dmem_req.write = ex_mem.ctrl.mem_write;

	assign mem_dest.valid = ex_mem.ctrl.valid && ex_mem.ctrl.load_regfile;
	assign mem_dest.reg_num = ex_mem.ctrl.dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			dmem_req_valid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (is_mem && !dmem_ack) begin // Previous ack must be gone
						state <= wait_ack;
						dmem_req_valid <= 1'b1;
					end
				end
				wait_ack: begin
					if (dmem_ack) begin
						state <= wait_release;
						dmem_req_valid <= 1'b0;
					end
				end
				wait_release: begin
					if (!dmem_ack) state <= done;
				end
				default: state <= idle; // done, MEM/WB takes the access
			endcase
		end
	end

	// Load word is only valid while ack is high
	always_ff @(posedge clk) begin
		if (state == wait_ack && dmem_ack && ex_mem.ctrl.mem_read) begin
			mdr <= dmem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb <= '0;
		end else begin
			mem_wb.ctrl <= ex_mem.ctrl;
			mem_wb.alu <= ex_mem.alu;
			mem_wb.mdr <= mdr;
			if (mem_busy) mem_wb.ctrl.valid <= 1'b0; // Bubble while waiting
		end
	end

endmodule : memory_module

`default_nettype wire

/* hw/writeback_module.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_module
(
	input logic clk,
	input logic reset,
	input lc3b_types::mem_wb_t mem_wb,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_word sr1_value,
	output lc3b_types::lc3b_word sr2_value
);

	import lc3b_types::*;

	reg_write_t wr;
	lc3b_word regfile [8];

	always_comb begin
		wr.en = mem_wb.ctrl.valid && mem_wb.ctrl.load_regfile;
		wr.reg_num = mem_wb.ctrl.dest;
		if (mem_wb.ctrl.opcode == op_ldr) begin
			wr.value = mem_wb.mdr;
		end else begin
			wr.value = mem_wb.alu;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				regfile[i] <= 16'h0000;
			end
		end else if (wr.en) begin
			regfile[wr.reg_num] <= wr.value;
		end
	end

	// Same-cycle bypass so decode needs no WB compare
	assign sr1_value = (wr.en && wr.reg_num == sr1) ? wr.value : regfile[sr1];
	assign sr2_value = (wr.en && wr.reg_num == sr2) ? wr.value : regfile[sr2];

endmodule : writeback_module

`default_nettype wire

/* hw/cpu_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath
(
	input logic clk,
	input logic reset,
	output lc3b_types::lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_types::lc3b_word mem_rdata1,
	output logic dmem_req_valid,
	output lc3b_types::dmem_req_t dmem_req,
	input logic dmem_ack,
	input lc3b_types::lc3b_word dmem_rdata
);

	import lc3b_types::*;

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	rf_dest_t ex_dest, mem_dest; // Writers still in flight
	lc3b_reg sr1, sr2;
	lc3b_word sr1_value, sr2_value;
	logic mem_busy;
	logic hazard_stall;
	logic hold;

	assign hold = mem_busy | hazard_stall;

	instruction_fetch if_stage (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.mem_rdata1(mem_rdata1),
		.mem_addr1(mem_addr1),
		.if_id(if_id),
		.mem_read1(mem_read1)
	);

	instruction_decode id_stage (
		.clk(clk),
		.reset(reset),
		.if_id(if_id),
		.sr1_value(sr1_value),
		.sr2_value(sr2_value),
		.ex_dest(ex_dest),
		.mem_dest(mem_dest),
		.mem_busy(mem_busy),
		.sr1(sr1),
		.sr2(sr2),
		.hazard_stall(hazard_stall),
		.id_ex(id_ex)
	);

	execution_module ex_stage (
		.clk(clk),
		.reset(reset),
		.mem_busy(mem_busy),
		.id_ex(id_ex),
		.ex_dest(ex_dest),
		.ex_mem(ex_mem)
	);

	memory_module mem_stage (
		.clk(clk),
		.reset(reset),
		.ex_mem(ex_mem),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req(dmem_req),
		.mem_busy(mem_busy),
		.mem_dest(mem_dest),
		.mem_wb(mem_wb)
	);

	writeback_module wb_stage (
		.clk(clk),
		.reset(reset),
		.mem_wb(mem_wb),
		.sr1(sr1),
		.sr2(sr2),
		.sr1_value(sr1_value),
		.sr2_value(sr2_value)
	);

endmodule : cpu_datapath

`default_nettype wire

/* dv/cpu_datapath_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath_asserts
(
	input logic clk,
	input logic reset,
	input logic dmem_req_valid,
	input logic dmem_ack,
	input lc3b_types::dmem_req_t dmem_req
);

	req_held: assert property (@(posedge clk) disable iff (reset)
		dmem_req_valid && !dmem_ack |=> dmem_req_valid)
		else $error("dmem_req_valid dropped before ack was seen");

	// Release phase, ack still high
	no_rise_under_ack: assert property (@(posedge clk) disable iff (reset)
		dmem_ack && !dmem_req_valid |=> !dmem_req_valid)
		else $error("dmem_req_valid rose while dmem_ack was high");

	req_stable: assert property (@(posedge clk) disable iff (reset)
		dmem_req_valid && $past(dmem_req_valid) |-> $stable(dmem_req))
		else $error("dmem_req changed while dmem_req_valid was high");

	reset_clears_req: assert property (@(posedge clk) reset |=> !dmem_req_valid)
		else $error("dmem_req_valid high after reset");

endmodule : cpu_datapath_asserts

bind cpu_datapath cpu_datapath_asserts handshake_checks (
	.clk(clk),
	.reset(reset),
	.dmem_req_valid(dmem_req_valid),
	.dmem_ack(dmem_ack),
	.dmem_req(dmem_req)
);

`default_nettype wire

/* dv/lc3b_ref_model.svh */
`ifndef LC3B_REF_MODEL_SVH
`define LC3B_REF_MODEL_SVH

// Architectural state, kept apart from the responder memory
lc3b_word model_regs [8];
lc3b_word model_mem [256];
dmem_req_t exp_store_q [$]; // Stores in program order
lc3b_word exp_load_q [$];

function automatic lc3b_word sign_extend(input lc3b_word value, input int width);
	lc3b_word mask;
	mask = 16'hffff << width;
	return value[width - 1] ? (value | mask) : (value & ~mask);
endfunction

// In-order execution of the whole program, one instruction at a time
task automatic run_model(input int length);
	lc3b_word ir;
	lc3b_word operand_b;
	lc3b_word addr;
	dmem_req_t store;
	for (int r = 0; r < 8; r++) model_regs[r] = 16'h0000;
	for (int pc = 0; pc < length; pc++) begin
		ir = program_rom[pc];
		operand_b = ir[5] ? sign_extend(ir, 5) : model_regs[ir[2:0]];
		addr = model_regs[ir[8:6]] + (sign_extend(ir, 6) << 1); // Offset counts words
		case (ir[15:12])
			4'b0001: model_regs[ir[11:9]] = model_regs[ir[8:6]] + operand_b;
			4'b0101: model_regs[ir[11:9]] = model_regs[ir[8:6]] & operand_b;
			4'b1001: model_regs[ir[11:9]] = ~model_regs[ir[8:6]];
			4'b0110: begin
				exp_load_q.push_back(addr);
				model_regs[ir[11:9]] = model_mem[addr[8:1]];
			end
			4'b0111: begin
				store.addr = addr;
				store.wdata = model_regs[ir[11:9]];
				store.write = 1'b1;
				exp_store_q.push_back(store);
				model_mem[addr[8:1]] = store.wdata;
			end
			default: ; // BR, JMP, TRAP and the rest act as NOP
		endcase
	end
endtask

`endif

/* dv/cpu_datapath_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_datapath_tb;

	import lc3b_types::*;

	localparam int prog_len = 200;
	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	// Each instruction gets 4 stall cycles and 10 handshake cycles
	localparam int watchdog_ns = prog_len * (4 + 10) * clk_period + reset_cycles * clk_period;

	logic clk;
	logic reset;
	lc3b_word mem_addr1;
	logic mem_read1;
	lc3b_word mem_rdata1;
	logic dmem_req_valid;
	dmem_req_t dmem_req;
	logic dmem_ack;
	lc3b_word dmem_rdata;

	lc3b_word program_rom [prog_len];
	lc3b_word data_mem [256];
	integer seed;
	int n_words;
	dmem_req_t seen_req;
	lc3b_word next_fetch_addr;

	`include "lc3b_ref_model.svh"

	cpu_datapath DUT (
		.clk(clk),
		.reset(reset),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req(dmem_req),
		.dmem_ack(dmem_ack),
		.dmem_rdata(dmem_rdata)
	);

	// Combinational instruction ROM that reads zero past the program
	assign mem_rdata1 = (mem_addr1[15:1] < prog_len) ? program_rom[mem_addr1[15:1]] : 16'h0000;

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic stop_on_error();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic emit(input lc3b_word word);
		program_rom[n_words] = word;
		n_words++;
	endtask

	task automatic gen_program();
		int pick;
		lc3b_reg dr;
		lc3b_reg sa;
		lc3b_reg sb;
		lc3b_reg base;
		logic [4:0] imm;
		logic [5:0] off;
		n_words = 0;
		emit({4'b0001, 3'd6, 3'd6, 1'b1, 5'(2 * rand_below(8))}); // R6 and R7 hold bases
		emit({4'b0001, 3'd7, 3'd7, 1'b1, 5'(2 * rand_below(8))});
		while (n_words < prog_len - 8) begin
			pick = rand_below(15);
			dr = 3'(rand_below(6));
			sa = 3'(rand_below(8));
			sb = 3'(rand_below(8));
			base = 3'(6 + rand_below(2));
			imm = 5'(rand_below(32));
			off = 6'(rand_below(32)); // Positive offsets keep addresses small
			case (pick)
				0, 1: emit({4'b0001, dr, sa, 3'b000, sb});
				2, 3: emit({4'b0001, dr, sa, 1'b1, imm});
				4: emit({4'b0101, dr, sa, 3'b000, sb});
				5: emit({4'b0101, dr, sa, 1'b1, imm});
				6: emit({4'b1001, dr, sa, 6'b111111});
				7, 8, 9: emit({4'b0110, dr, base, off});
				10, 11: emit({4'b0111, sa, base, off});
				12: emit({4'b0000, 12'(rand_below(4096))});
				13: emit({(rand_below(2) != 0) ? 4'(2 + rand_below(3)) : 4'(10 + rand_below(6)),
					12'(rand_below(4096))});
				default: begin
					if (n_words < prog_len - 9) begin
						emit({4'b0101, base, base, 1'b1, 5'd0});
						emit({4'b0001, base, base, 1'b1, 5'(2 * rand_below(8))});
					end else begin
						emit(16'h0000);
					end
				end
			endcase
		end
		for (int i = 0; i < 8; i++) emit({4'b0111, 3'(i), 3'd6, 6'(24 + i)});
	endtask

	task automatic check_store(input dmem_req_t got);
		dmem_req_t expected;
		if (exp_store_q.size() == 0) begin
			$display("Store to %h issued after the last store of the program", got.addr);
			stop_on_error();
		end else begin
			expected = exp_store_q.pop_front();
			if (got !== expected) begin
				$display("** Error @ %0t ns: store addr %h data %h, expected addr %h data %h",
					$time, got.addr, got.wdata, expected.addr, expected.wdata);
				stop_on_error();
			end
		end
	endtask

	task automatic check_load_addr(input lc3b_word got);
		lc3b_word expected;
		if (exp_load_q.size() == 0) begin
			$display("Load from %h issued after the last load of the program", got);
			stop_on_error();
		end else begin
			expected = exp_load_q.pop_front();
			if (got !== expected) begin
				$display("** Error @ %0t ns: load addr %h, expected %h", $time, got, expected);
				stop_on_error();
			end
		end
	endtask

	task automatic check_fetch_addr(input lc3b_word got, input lc3b_word expected);
		if (got !== expected) begin
			$display("** Error @ %0t ns: fetch addr %h, expected %h", $time, got, expected);
			stop_on_error();
		end
	endtask

	// PC starts at 0 and moves one word on each cycle the instruction port reads
	always @(posedge clk) begin
		if (reset) begin
			next_fetch_addr = 16'h0000;
		end else begin
			check_fetch_addr(mem_addr1, next_fetch_addr);
			if (mem_read1) next_fetch_addr = next_fetch_addr + 16'd2;
		end
	end

	// Four-phase responder with random ack delays
	always begin
		@(posedge clk);
		if (!reset && dmem_req_valid && !dmem_ack) begin
			seen_req = dmem_req;
			if (seen_req.write) check_store(seen_req);
			else check_load_addr(seen_req.addr);
			repeat (rand_below(5)) @(posedge clk);
			dmem_ack <= 1'b1;
			dmem_rdata <= data_mem[seen_req.addr[8:1]];
			if (seen_req.write) data_mem[seen_req.addr[8:1]] = seen_req.wdata;
			@(posedge clk);
			while (dmem_req_valid) @(posedge clk);
			repeat (rand_below(5)) @(posedge clk);
			dmem_ack <= 1'b0;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the pipeline stopped making progress",
			watchdog_ns);
		stop_on_error();
	end

	initial begin
		seed = 17;
		reset = 1'b1;
		dmem_ack = 1'b0;
		dmem_rdata = 16'h0000;
		gen_program();
		for (int i = 0; i < 256; i++) begin
			data_mem[i] = 16'($random(seed));
			model_mem[i] = data_mem[i];
		end
		run_model(prog_len);
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		while (exp_store_q.size() != 0) @(posedge clk);
		repeat (40) @(posedge clk); // Trailing NOPs must stay off the bus
		if (exp_load_q.size() != 0) begin
			$display("%0d loads of the program were never issued", exp_load_q.size());
			stop_on_error();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule : cpu_datapath_tb

`default_nettype wire

/* cpu_datapath.f */
+incdir+dv
hw/lc3b_types.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execution_module.sv
hw/memory_module.sv
hw/writeback_module.sv
hw/cpu_datapath.sv
dv/cpu_datapath_asserts.sv
dv/cpu_datapath_tb.sv

/* Bender.yml */
package:
  name: cpu_datapath

sources:
  - hw/lc3b_types.sv
  - hw/instruction_fetch.sv
  - hw/instruction_decode.sv
  - hw/execution_module.sv
  - hw/memory_module.sv
  - hw/writeback_module.sv
  - hw/cpu_datapath.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cpu_datapath_asserts.sv
      - dv/cpu_datapath_tb.sv
